// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_id_stage
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -F -x -- '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: hw/id_ctrl_if.sv
interface id_ctrl_if;
    import rv_id_pkg::*;

    // Register addresses and operands
    reg_addr_t    rd_addr;
    reg_addr_t    rs1_addr;
    reg_addr_t    rs2_addr;
    word_t        imm1;
    word_t        imm2;

    // Control
    alu_src_t     alu_src;
    alu_op_t      alu_op;
    branch_kind_t branch_kind;
    logic         branch_flag;
    logic         mem_wr_en;
    logic         mem_rd_en;
    logic         rd_wr_en;
    logic         memtoreg;
    logic         jump_en;
    mem_op_t      mem_op;
    logic         exception;

    modport decoder (
        output rd_addr, rs1_addr, rs2_addr, imm1, imm2,
        output alu_src, alu_op, branch_kind, branch_flag,
        output mem_wr_en, mem_rd_en, rd_wr_en, memtoreg, jump_en, mem_op, exception
    );

    modport stage (
        input rd_addr, rs1_addr, rs2_addr, imm1, imm2,
        input alu_src, alu_op, branch_kind, branch_flag,
        input mem_wr_en, mem_rd_en, rd_wr_en, memtoreg, jump_en, mem_op, exception
    );

endinterface

// File: hw/rv_decoder.sv
module rv_decoder (
    input  rv_id_pkg::instr_t instr_i,
    input  rv_id_pkg::word_t  pc_i,
    id_ctrl_if.decoder        ctrl
);
    import rv_id_pkg::*;

    // ==============================
    // Instruction fields
    // ==============================

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_alt;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // Set for the opcode classes that write rd, before the x0 check
    logic writes_rd;
    logic is_env_call;

    assign opcode     = instr_i[6:0];
    assign rd         = instr_i[11:7];
    assign funct3     = instr_i[14:12];
    assign rs1        = instr_i[19:15];
    assign rs2        = instr_i[24:20];
    assign funct7_alt = instr_i[30];

    // Sign-extended immediates, one per format
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'h000};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // ECALL has imm 0 and EBREAK imm 1, all other fields zero
    assign is_env_call = (funct3 == 3'b000) && (rd == '0) && (rs1 == '0) &&
                         (instr_i[31:21] == '0);

    // Integer ALU operation from funct3, alt picks SUB or SRA
    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // ==============================
    // Control decode
    // ==============================

    always_comb begin
        ctrl.rd_addr     = rd;
        ctrl.rs1_addr    = rs1;
        ctrl.rs2_addr    = rs2;
        ctrl.imm1        = '0;
        ctrl.imm2        = '0;
        ctrl.alu_src     = SRC_REG;
        ctrl.alu_op      = ALU_ADD;
        ctrl.branch_kind = BR_NONE;
        ctrl.branch_flag = 1'b0;
        ctrl.mem_wr_en   = 1'b0;
        ctrl.mem_rd_en   = 1'b0;
        ctrl.memtoreg    = 1'b0;
        ctrl.jump_en     = 1'b0;
        ctrl.mem_op      = '0;
        ctrl.exception   = 1'b0;
        writes_rd        = 1'b0;

        case (opcode)
            OPC_LUI: begin
                // 0 + imm
                ctrl.imm2    = imm_u;
                ctrl.alu_src = SRC_PC;
                writes_rd    = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.imm1    = pc_i;
                ctrl.imm2    = imm_u;
                ctrl.alu_src = SRC_PC;
                writes_rd    = 1'b1;
            end
            OPC_JAL: begin
                ctrl.imm1        = pc_i;
                ctrl.imm2        = imm_j;
                ctrl.alu_src     = SRC_LINK;
                ctrl.branch_kind = BR_PC_REL;
                ctrl.jump_en     = 1'b1;
                writes_rd        = 1'b1;
            end
            OPC_JALR: begin
                ctrl.imm1        = pc_i;
                ctrl.imm2        = imm_i;
                ctrl.alu_src     = SRC_LINK;
                ctrl.branch_kind = BR_REG;
                ctrl.jump_en     = 1'b1;
                writes_rd        = 1'b1;
            end
            OPC_BRANCH: begin
                // Compare by subtraction, condition rides in mem_op
                ctrl.imm2        = imm_b;
                ctrl.alu_op      = ALU_SUB;
                ctrl.branch_kind = BR_PC_REL;
                ctrl.branch_flag = 1'b1;
                ctrl.mem_op      = {1'b0, funct3};
            end
            OPC_LOAD: begin
                ctrl.imm2      = imm_i;
                ctrl.alu_src   = SRC_IMM;
                ctrl.mem_rd_en = 1'b1;
                ctrl.memtoreg  = 1'b1;
                ctrl.mem_op    = {1'b0, funct3};
                writes_rd      = 1'b1;
            end
            OPC_STORE: begin
                ctrl.imm2      = imm_s;
                ctrl.alu_src   = SRC_IMM;
                ctrl.mem_wr_en = 1'b1;
                ctrl.mem_op    = {1'b1, funct3};
            end
            OPC_OP_IMM: begin
                // Only SRAI uses the funct7 bit, ADDI has no subtract form
                ctrl.imm2    = imm_i;
                ctrl.alu_src = SRC_IMM;
                ctrl.alu_op  = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7_alt);
                writes_rd    = 1'b1;
            end
            OPC_OP: begin
                ctrl.alu_op = alu_from_funct3(funct3, funct7_alt);
                writes_rd   = 1'b1;
            end
            OPC_SYSTEM: begin
                // CSR forms fall through as a NOP
                ctrl.exception = is_env_call;
            end
            default: begin
                ctrl.alu_op = ALU_ADD;
            end
        endcase

        // Never write x0
        ctrl.rd_wr_en = writes_rd && (rd != '0);
    end

    always_comb begin
        if (ctrl.exception) begin
            assert (!(ctrl.mem_wr_en || ctrl.mem_rd_en || ctrl.rd_wr_en || ctrl.jump_en))
                else $error("Decoder raised an exception with an enable set");
        end
    end

endmodule

// File: hw/rv_id_pkg.sv
package rv_id_pkg;

    // ==============================
    // Widths and vector types
    // ==============================

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [31:0]           instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Bit 3 marks a store, bits 2..0 carry funct3 (branch condition for branches)
    typedef logic [3:0] mem_op_t;

    // ==============================
    // RV32I major opcodes
    // ==============================

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // ==============================
    // Control encodings
    // ==============================

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // Operand pairs: rs1/rs2, rs1/imm2, imm1/imm2, imm1/4
    typedef enum logic [1:0] {
        SRC_REG  = 2'd0,
        SRC_IMM  = 2'd1,
        SRC_PC   = 2'd2,
        SRC_LINK = 2'd3
    } alu_src_t;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_PC_REL = 2'd1,
        BR_REG    = 2'd2
    } branch_kind_t;

endpackage

// File: hw/rv_id_stage.sv
module rv_id_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      stall_i,
    input  logic                      flush_i,

    // From fetch
    input  rv_id_pkg::word_t          if_pc_i,
    input  rv_id_pkg::instr_t         if_instr_i,

    // Execute stage result, used for JALR forwarding
    input  logic                      ex_rd_wr_en_i,
    input  rv_id_pkg::reg_addr_t      ex_rd_addr_i,
    input  rv_id_pkg::word_t          ex_alu_result_i,

    // Writeback into the register file
    input  logic                      wb_rd_wr_en_i,
    input  rv_id_pkg::reg_addr_t      wb_rd_addr_i,
    input  rv_id_pkg::word_t          wb_rd_wr_data_i,

    output rv_id_pkg::word_t          id_pc_o,
    output rv_id_pkg::word_t          id_pc_dest_o,
    output rv_id_pkg::word_t          id_imm1_o,
    output rv_id_pkg::word_t          id_imm2_o,
    output rv_id_pkg::word_t          id_rs1_data_o,
    output rv_id_pkg::word_t          id_rs2_data_o,

    output rv_id_pkg::reg_addr_t      id_rd_addr_o,
    output rv_id_pkg::reg_addr_t      id_rs1_addr_o,
    output rv_id_pkg::reg_addr_t      id_rs2_addr_o,

    output rv_id_pkg::alu_src_t       id_alu_src_o,
    output rv_id_pkg::alu_op_t        id_alu_op_o,
    output rv_id_pkg::branch_kind_t   id_branch_kind_o,
    output rv_id_pkg::mem_op_t        id_mem_op_o,

    output logic                      id_branch_flag_o,
    output logic                      id_mem_wr_en_o,
    output logic                      id_mem_rd_en_o,
    output logic                      id_rd_wr_en_o,
    output logic                      id_memtoreg_o,
    output logic                      id_jump_en_o,
    output logic                      id_exception_o
);
    import rv_id_pkg::*;

    id_ctrl_if ctrl ();

    logic  fwd_rs1;
    word_t br_base;
    word_t br_sum;

    // ==============================
    // Decoder and register file
    // ==============================

    rv_decoder u_decoder (
        .instr_i (if_instr_i),
        .pc_i    (if_pc_i),
        .ctrl    (ctrl)
    );

    // Read with the registered addresses so data lines up with the EX stage
    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (id_rs1_addr_o),
        .rs2_addr_i (id_rs2_addr_o),
        .wr_addr_i  (wb_rd_addr_i),
        .wr_data_i  (wb_rd_wr_data_i),
        .wr_en_i    (wb_rd_wr_en_i),
        .rs1_data_o (id_rs1_data_o),
        .rs2_data_o (id_rs2_data_o)
    );

    // ==============================
    // Branch destination
    // ==============================

    // JALR base may still be in flight in EX
    assign fwd_rs1 = (id_branch_kind_o == BR_REG) && ex_rd_wr_en_i &&
                     (ex_rd_addr_i == id_rs1_addr_o) && (id_rs1_addr_o != '0);

    assign br_base = (id_branch_kind_o != BR_REG) ? id_pc_o :
                     fwd_rs1                      ? ex_alu_result_i :
                                                    id_rs1_data_o;
    assign br_sum  = br_base + id_imm2_o;

    // JALR clears bit 0 of the target
    assign id_pc_dest_o = (id_branch_kind_o == BR_REG) ? {br_sum[XLEN-1:1], 1'b0} : br_sum;

    // ==============================
    // ID/EX pipeline register
    // ==============================

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            // All zero is a NOP
            id_pc_o          <= '0;
            id_imm1_o        <= '0;
            id_imm2_o        <= '0;
            id_rd_addr_o     <= '0;
            id_rs1_addr_o    <= '0;
            id_rs2_addr_o    <= '0;
            id_alu_src_o     <= SRC_REG;
            id_alu_op_o      <= ALU_ADD;
            id_branch_kind_o <= BR_NONE;
            id_mem_op_o      <= '0;
            id_branch_flag_o <= 1'b0;
            id_mem_wr_en_o   <= 1'b0;
            id_mem_rd_en_o   <= 1'b0;
            id_rd_wr_en_o    <= 1'b0;
            id_memtoreg_o    <= 1'b0;
            id_jump_en_o     <= 1'b0;
            id_exception_o   <= 1'b0;
        end else if (stall_i) begin
            // Bubble, everything else holds
            id_mem_wr_en_o   <= 1'b0;
            id_mem_rd_en_o   <= 1'b0;
            id_rd_wr_en_o    <= 1'b0;
            id_jump_en_o     <= 1'b0;
        end else begin
            id_pc_o          <= if_pc_i;
            id_imm1_o        <= ctrl.imm1;
            id_imm2_o        <= ctrl.imm2;
            id_rd_addr_o     <= ctrl.rd_addr;
            id_rs1_addr_o    <= ctrl.rs1_addr;
            id_rs2_addr_o    <= ctrl.rs2_addr;
            id_alu_src_o     <= ctrl.alu_src;
            id_alu_op_o      <= ctrl.alu_op;
            id_branch_kind_o <= ctrl.branch_kind;
            id_mem_op_o      <= ctrl.mem_op;
            id_branch_flag_o <= ctrl.branch_flag;
            id_mem_wr_en_o   <= ctrl.mem_wr_en;
            id_mem_rd_en_o   <= ctrl.mem_rd_en;
            id_rd_wr_en_o    <= ctrl.rd_wr_en;
            id_memtoreg_o    <= ctrl.memtoreg;
            id_jump_en_o     <= ctrl.jump_en;
            id_exception_o   <= ctrl.exception;
        end
    end

    a_stall_bubble: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (stall_i && !flush_i) |=>
            !(id_mem_wr_en_o || id_mem_rd_en_o || id_rd_wr_en_o || id_jump_en_o)
    ) else $error("Enable still set in the cycle after a stall");

endmodule

// File: hw/rv_regfile.sv
module rv_regfile (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  rv_id_pkg::reg_addr_t rs1_addr_i,
    input  rv_id_pkg::reg_addr_t rs2_addr_i,
    input  rv_id_pkg::reg_addr_t wr_addr_i,
    input  rv_id_pkg::word_t     wr_data_i,
    input  logic                 wr_en_i,
    output rv_id_pkg::word_t     rs1_data_o,
    output rv_id_pkg::word_t     rs2_data_o
);
    import rv_id_pkg::*;

    // x1..x31, x0 has no storage
    word_t regs [1:NUM_REGS-1];

    // ==============================
    // Write port
    // ==============================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // ==============================
    // Read ports
    // ==============================

    // No bypass from the write port, a write shows up the cycle after
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    a_x0_rs1_zero: assert property (
        @(posedge clk_i) (rs1_addr_i == '0) |-> (rs1_data_o == '0)
    ) else $error("Register file returned nonzero data for x0 on rs1");

    a_x0_rs2_zero: assert property (
        @(posedge clk_i) (rs2_addr_i == '0) |-> (rs2_data_o == '0)
    ) else $error("Register file returned nonzero data for x0 on rs2");

endmodule

// File: verification/id_checker.sv
module id_checker (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  rv_id_pkg::word_t        if_pc_i,
    input  rv_id_pkg::instr_t       if_instr_i,
    input  logic                    ex_rd_wr_en_i,
    input  rv_id_pkg::reg_addr_t    ex_rd_addr_i,
    input  rv_id_pkg::word_t        ex_alu_result_i,
    input  logic                    wb_rd_wr_en_i,
    input  rv_id_pkg::reg_addr_t    wb_rd_addr_i,
    input  rv_id_pkg::word_t        wb_rd_wr_data_i,
    input  rv_id_pkg::word_t        id_pc_o,
    input  rv_id_pkg::word_t        id_pc_dest_o,
    input  rv_id_pkg::word_t        id_imm1_o,
    input  rv_id_pkg::word_t        id_imm2_o,
    input  rv_id_pkg::word_t        id_rs1_data_o,
    input  rv_id_pkg::word_t        id_rs2_data_o,
    input  rv_id_pkg::reg_addr_t    id_rd_addr_o,
    input  rv_id_pkg::reg_addr_t    id_rs1_addr_o,
    input  rv_id_pkg::reg_addr_t    id_rs2_addr_o,
    input  rv_id_pkg::alu_src_t     id_alu_src_o,
    input  rv_id_pkg::alu_op_t      id_alu_op_o,
    input  rv_id_pkg::branch_kind_t id_branch_kind_o,
    input  rv_id_pkg::mem_op_t      id_mem_op_o,
    input  logic                    id_branch_flag_o,
    input  logic                    id_mem_wr_en_o,
    input  logic                    id_mem_rd_en_o,
    input  logic                    id_rd_wr_en_o,
    input  logic                    id_memtoreg_o,
    input  logic                    id_jump_en_o,
    input  logic                    id_exception_o,
    output int                      mismatch_count_o,
    output int                      fault_count_o,
    output int                      check_count_o
);
    import rv_id_pkg::*;

    typedef struct packed {
        word_t      pc;
        word_t      imm1;
        word_t      imm2;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [1:0] alu_src;
        logic [3:0] alu_op;
        logic [1:0] br_kind;
        mem_op_t    mem_op;
        logic       branch_flag, mem_wr, mem_rd, rd_wr, memtoreg, jump, exc;
    } dec_t;

    dec_t  model_q;
    word_t regs [32];
    logic  armed = 1'b0;
    int    mismatch_count = 0;
    int    fault_count = 0;
    int    check_count = 0;

    assign mismatch_count_o = mismatch_count;
    assign fault_count_o    = fault_count;
    assign check_count_o    = check_count;

    function automatic logic [3:0] alu_for_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: return alt ? ALU_SUB : ALU_ADD;
            3'd1: return ALU_SLL;
            3'd2: return ALU_SLT;
            3'd3: return ALU_SLTU;
            3'd4: return ALU_XOR;
            3'd5: return alt ? ALU_SRA : ALU_SRL;
            3'd6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ==============================
    // Reference decode
    // ==============================

    function automatic dec_t decode_instr(input instr_t ins, input word_t pc);
        dec_t       d;
        logic [2:0] f3;
        word_t      i_imm;
        word_t      s_imm;
        word_t      b_imm;
        word_t      u_imm;
        word_t      j_imm;
        f3    = ins[14:12];
        i_imm = $signed(ins[31:20]);
        s_imm = $signed({ins[31:25], ins[11:7]});
        b_imm = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
        u_imm = {ins[31:12], 12'b0};
        j_imm = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
        d     = '0;
        d.pc  = pc;
        d.rd  = ins[11:7];
        d.rs1 = ins[19:15];
        d.rs2 = ins[24:20];
        case (ins[6:0])
            OPC_LUI: begin
                d.imm2 = u_imm;
                d.alu_src = SRC_PC;
                d.rd_wr = 1'b1;
            end
            OPC_AUIPC: begin
                d.imm1 = pc;
                d.imm2 = u_imm;
                d.alu_src = SRC_PC;
                d.rd_wr = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                d.imm1 = pc;
                d.imm2 = (ins[6:0] == OPC_JAL) ? j_imm : i_imm;
                d.alu_src = SRC_LINK;
                d.br_kind = (ins[6:0] == OPC_JAL) ? BR_PC_REL : BR_REG;
                d.jump = 1'b1;
                d.rd_wr = 1'b1;
            end
            OPC_BRANCH: begin
                d.imm2 = b_imm;
                d.alu_op = ALU_SUB;
                d.br_kind = BR_PC_REL;
                d.branch_flag = 1'b1;
                d.mem_op = {1'b0, f3};
            end
            OPC_LOAD: begin
                d.imm2 = i_imm;
                d.alu_src = SRC_IMM;
                d.mem_rd = 1'b1;
                d.memtoreg = 1'b1;
                d.rd_wr = 1'b1;
                d.mem_op = {1'b0, f3};
            end
            OPC_STORE: begin
                d.imm2 = s_imm;
                d.alu_src = SRC_IMM;
                d.mem_wr = 1'b1;
                d.mem_op = {1'b1, f3};
            end
            OPC_OP_IMM: begin
                d.imm2 = i_imm;
                d.alu_src = SRC_IMM;
                d.alu_op = alu_for_funct3(f3, (f3 == 3'd5) && ins[30]);
                d.rd_wr = 1'b1;
            end
            OPC_OP: begin
                d.alu_op = alu_for_funct3(f3, ins[30]);
                d.rd_wr = 1'b1;
            end
            OPC_SYSTEM: begin
                // ECALL or EBREAK only
                d.exc = (ins[31:21] == '0) && (ins[19:7] == '0);
            end
            default: begin
                d.alu_op = ALU_ADD;
            end
        endcase
        if (d.rd == '0) begin
            d.rd_wr = 1'b0;
        end
        return d;
    endfunction

    task automatic compare_field(input string name, input word_t exp_v, input word_t act_v);
        check_count++;
        if (act_v !== exp_v) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    // Expected pipeline register and register file, updated on each edge
    always @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            model_q = '0;
        end else if (stall_i) begin
            model_q.mem_wr = 1'b0;
            model_q.mem_rd = 1'b0;
            model_q.rd_wr  = 1'b0;
            model_q.jump   = 1'b0;
        end else begin
            model_q = decode_instr(if_instr_i, if_pc_i);
        end
        if (rst_i) begin
            foreach (regs[i]) regs[i] = '0;
            armed = 1'b1;
        end else if (wb_rd_wr_en_i && wb_rd_addr_i != '0) begin
            regs[wb_rd_addr_i] = wb_rd_wr_data_i;
        end
    end

    // ==============================
    // Output comparison
    // ==============================

    always @(negedge clk_i) begin : compare_outputs
        word_t base;
        word_t dest;
        if (armed) begin
            if ($isunknown({id_pc_o, id_pc_dest_o, id_imm1_o, id_imm2_o, id_rs1_data_o,
                            id_rs2_data_o, id_rd_addr_o, id_rs1_addr_o, id_rs2_addr_o,
                            id_alu_src_o, id_alu_op_o, id_branch_kind_o, id_mem_op_o,
                            id_branch_flag_o, id_mem_wr_en_o, id_mem_rd_en_o,
                            id_rd_wr_en_o, id_memtoreg_o, id_jump_en_o, id_exception_o})) begin
                fault_count++;
                $display("Unknown value on a DUT output at time %0t", $time);
            end
            compare_field("id_pc_o", model_q.pc, id_pc_o);
            compare_field("id_imm1_o", model_q.imm1, id_imm1_o);
            compare_field("id_imm2_o", model_q.imm2, id_imm2_o);
            compare_field("id_rd_addr_o", 32'(model_q.rd), 32'(id_rd_addr_o));
            compare_field("id_rs1_addr_o", 32'(model_q.rs1), 32'(id_rs1_addr_o));
            compare_field("id_rs2_addr_o", 32'(model_q.rs2), 32'(id_rs2_addr_o));
            compare_field("id_alu_src_o", 32'(model_q.alu_src), 32'(id_alu_src_o));
            compare_field("id_alu_op_o", 32'(model_q.alu_op), 32'(id_alu_op_o));
            compare_field("id_branch_kind_o", 32'(model_q.br_kind), 32'(id_branch_kind_o));
            compare_field("id_mem_op_o", 32'(model_q.mem_op), 32'(id_mem_op_o));
            compare_field("id_branch_flag_o", 32'(model_q.branch_flag), 32'(id_branch_flag_o));
            compare_field("id_mem_wr_en_o", 32'(model_q.mem_wr), 32'(id_mem_wr_en_o));
            compare_field("id_mem_rd_en_o", 32'(model_q.mem_rd), 32'(id_mem_rd_en_o));
            compare_field("id_rd_wr_en_o", 32'(model_q.rd_wr), 32'(id_rd_wr_en_o));
            compare_field("id_memtoreg_o", 32'(model_q.memtoreg), 32'(id_memtoreg_o));
            compare_field("id_jump_en_o", 32'(model_q.jump), 32'(id_jump_en_o));
            compare_field("id_exception_o", 32'(model_q.exc), 32'(id_exception_o));
            compare_field("id_rs1_data_o", regs[model_q.rs1], id_rs1_data_o);
            compare_field("id_rs2_data_o", regs[model_q.rs2], id_rs2_data_o);

            // Destination only defined for the two branch kinds
            if (model_q.br_kind == BR_REG) begin
                if (ex_rd_wr_en_i && ex_rd_addr_i == model_q.rs1 && model_q.rs1 != '0)
                    base = ex_alu_result_i;
                else
                    base = regs[model_q.rs1];
                dest = (base + model_q.imm2) & 32'hffff_fffe;
                compare_field("id_pc_dest_o", dest, id_pc_dest_o);
            end else if (model_q.br_kind == BR_PC_REL) begin
                dest = model_q.pc + model_q.imm2;
                compare_field("id_pc_dest_o", dest, id_pc_dest_o);
            end
        end
    end

endmodule

// File: verification/tb_id_stage.sv
module tb_id_stage;
    import rv_id_pkg::*;

    localparam int NUM_INSTR      = 3000;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_INSTR + 200;

    logic         clk_i;
    logic         rst_i;
    logic         stall_i;
    logic         flush_i;
    word_t        if_pc_i;
    instr_t       if_instr_i;
    logic         ex_rd_wr_en_i;
    reg_addr_t    ex_rd_addr_i;
    word_t        ex_alu_result_i;
    logic         wb_rd_wr_en_i;
    reg_addr_t    wb_rd_addr_i;
    word_t        wb_rd_wr_data_i;

    word_t        id_pc_o;
    word_t        id_pc_dest_o;
    word_t        id_imm1_o;
    word_t        id_imm2_o;
    word_t        id_rs1_data_o;
    word_t        id_rs2_data_o;
    reg_addr_t    id_rd_addr_o;
    reg_addr_t    id_rs1_addr_o;
    reg_addr_t    id_rs2_addr_o;
    alu_src_t     id_alu_src_o;
    alu_op_t      id_alu_op_o;
    branch_kind_t id_branch_kind_o;
    mem_op_t      id_mem_op_o;
    logic         id_branch_flag_o;
    logic         id_mem_wr_en_o;
    logic         id_mem_rd_en_o;
    logic         id_rd_wr_en_o;
    logic         id_memtoreg_o;
    logic         id_jump_en_o;
    logic         id_exception_o;

    int           mismatch_count_o;
    int           fault_count_o;
    int           check_count_o;

    integer       seed = 32'hefef_a5df;
    int           cycle_count = 0;

    rv_id_stage DUT (.*);

    id_checker u_checker (.*);

    always #4 clk_i = ~clk_i;

    // Hard stop in case the stimulus loop never ends
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic is_known_opcode(input logic [6:0] opc);
        case (opc)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
            OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_SYSTEM: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // ==============================
    // Weighted instruction mix
    // ==============================

    function automatic instr_t random_instr();
        instr_t ins;
        int     pick;
        ins  = $random(seed);
        pick = int'($unsigned($random(seed)) % 100);
        if (pick < 8) ins[6:0] = OPC_LUI;
        else if (pick < 15) ins[6:0] = OPC_AUIPC;
        else if (pick < 23) ins[6:0] = OPC_JAL;
        else if (pick < 33) begin
            ins[6:0]   = OPC_JALR;
            ins[14:12] = 3'b000;
        end
        else if (pick < 46) ins[6:0] = OPC_BRANCH;
        else if (pick < 56) ins[6:0] = OPC_LOAD;
        else if (pick < 64) ins[6:0] = OPC_STORE;
        else if (pick < 76) ins[6:0] = OPC_OP_IMM;
        else if (pick < 88) begin
            // funct7 is either all zero or the SUB/SRA form
            ins[6:0]   = OPC_OP;
            ins[31:25] = {1'b0, ins[30], 5'b00000};
        end
        else if (pick < 92) ins = ins[0] ? 32'h0010_0073 : 32'h0000_0073;
        else if (pick < 95) ins[6:0] = OPC_SYSTEM;
        else begin
            while (is_known_opcode(ins[6:0])) begin
                ins[6:0] = 7'($random(seed));
            end
        end
        // Extra weight on rd = x0
        if (pick < 88 && ($unsigned($random(seed)) % 8) == 0) begin
            ins[11:7] = '0;
        end
        return ins;
    endfunction

    task automatic drive_random_cycle();
        int roll;
        if_instr_i <= random_instr();
        if_pc_i    <= $random(seed) & 32'hffff_fffc;
        roll = int'($unsigned($random(seed)) % 100);
        stall_i    <= (roll < 10);
        roll = int'($unsigned($random(seed)) % 100);
        flush_i    <= (roll < 5);
        // Half the time EX targets the rs1 of the instruction now being registered
        ex_rd_wr_en_i   <= 1'($random(seed));
        ex_rd_addr_i    <= $random(seed) & 1 ? if_instr_i[19:15] : 5'($random(seed));
        ex_alu_result_i <= $random(seed);
        roll = int'($unsigned($random(seed)) % 100);
        wb_rd_wr_en_i   <= (roll < 70);
        wb_rd_addr_i    <= 5'($random(seed));
        wb_rd_wr_data_i <= $random(seed);
    endtask

    initial begin
        clk_i           = 1'b0;
        rst_i           = 1'b1;
        stall_i         = 1'b0;
        flush_i         = 1'b0;
        if_pc_i         = '0;
        if_instr_i      = '0;
        ex_rd_wr_en_i   = 1'b0;
        ex_rd_addr_i    = '0;
        ex_alu_result_i = '0;
        wb_rd_wr_en_i   = 1'b0;
        wb_rd_addr_i    = '0;
        wb_rd_wr_data_i = '0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            drive_random_cycle();
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        #1;

        $display("Summary: %0d mismatches, %0d other errors, %0d checks",
                 mismatch_count_o, fault_count_o, check_count_o);
        if (mismatch_count_o == 0 && fault_count_o == 0 && check_count_o > 0) begin
            $display(">>> PASS");
        end else begin
            if (check_count_o == 0) begin
                $display("No DUT output was ever checked");
            end
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/rv_id_pkg.sv
hw/id_ctrl_if.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_id_stage.sv
verification/id_checker.sv
verification/tb_id_stage.sv
